// File: hdl/vseq_pkg.sv
// Vector sequencer definitions

package vseq_pkg;

  ////////////////////
  // Register file
  ////////////////////

  // Number of architectural vector registers
  // Each access list in the hazard checker keeps one entry per register
  localparam int unsigned NrVRegs = 32;

  // Register v0 holds the mask of masked instructions
  localparam int unsigned VMaskReg = 0;

  // Index of a vector register
  typedef logic [4:0] vreg_t;

  ////////////////////
  // Operations
  ////////////////////

  // Operation class of an instruction
  // The class alone decides which processing elements run the instruction
  typedef enum logic [1:0] {
    // Runs on every lane
    OP_ALU   = 2'd0,
    // Runs on the vector load unit
    OP_LOAD  = 2'd1,
    // Runs on the vector store unit
    OP_STORE = 2'd2
  } op_e;

  ////////////////////
  // PE layout
  ////////////////////

  // The lanes occupy PE indices 0 to NrLanes-1
  // The memory units follow right after the last lane
  localparam int unsigned OffsetLoad  = 0;
  localparam int unsigned OffsetStore = 1;

endpackage

// File: hdl/vseq_issue_if.sv
// Instruction issue bus

interface vseq_issue_if #(
  parameter int unsigned NrVInsn = 8
);
  import vseq_pkg::*;

  // Width of an instruction ID
  localparam int unsigned IdW = (NrVInsn > 1) ? $clog2(NrVInsn) : 1;

  // Single-cycle strobe for an accepted instruction
  logic           accept;
  logic [IdW-1:0] id;
  op_e            op;
  logic           vm;
  vreg_t          vs1;
  logic           use_vs1;
  vreg_t          vs2;
  logic           use_vs2;
  vreg_t          vd;
  logic           use_vd;

  // One bit per in-flight ID that the new instruction depends on
  logic [NrVInsn-1:0] hazard_vs1;
  logic [NrVInsn-1:0] hazard_vs2;
  logic [NrVInsn-1:0] hazard_vd;
  logic [NrVInsn-1:0] hazard_vm;

  // High while the issue register still waits for the lanes
  logic hold;

  modport producer (
    output accept, id, op, vm, vs1, use_vs1, vs2, use_vs2, vd, use_vd,
    output hazard_vs1, hazard_vs2, hazard_vd, hazard_vm,
    input  hold
  );

  modport buffer (
    input  accept, id, op, vm, vs1, vs2, vd,
    input  hazard_vs1, hazard_vs2, hazard_vd, hazard_vm,
    output hold
  );

  modport tracker (
    input accept, id, op, hazard_vs1, hazard_vs2, hazard_vd, hazard_vm
  );

endinterface

// File: hdl/vseq_hazard_check.sv
// Hazard checker and request acceptance

module vseq_hazard_check #(
  parameter  int unsigned NrVInsn = 8,
  localparam int unsigned IdW     = (NrVInsn > 1) ? $clog2(NrVInsn) : 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Incoming vector instruction
  input  logic                  req_valid_i,
  input  vseq_pkg::op_e         req_op_i,
  input  logic                  req_vm_i,
  input  vseq_pkg::vreg_t       req_vs1_i,
  input  logic                  req_use_vs1_i,
  input  vseq_pkg::vreg_t       req_vs2_i,
  input  logic                  req_use_vs2_i,
  input  vseq_pkg::vreg_t       req_vd_i,
  input  logic                  req_use_vd_i,
  output logic                  req_ready_o,
  // State from the tracker
  input  logic    [NrVInsn-1:0] running_i,
  input  logic        [IdW-1:0] next_id_i,
  input  logic                  full_i,
  // Accepted instruction towards the issue register and the tracker
  vseq_issue_if.producer        issue
);
  import vseq_pkg::*;

  // One access list entry names the last ID that touched a register
  typedef struct packed {
    logic [IdW-1:0] vid;
    logic           valid;
  } access_t;

  // Expand an entry into a vector with the bit of its ID set
  function automatic logic [NrVInsn-1:0] id_vec(access_t entry);
    logic [NrVInsn-1:0] vec;
    vec            = '0;
    vec[entry.vid] = entry.valid;
    return vec;
  endfunction

  ////////////////////
  // Access lists
  ////////////////////

  access_t [NrVRegs-1:0] write_list_q, write_list_d, write_live;
  access_t [NrVRegs-1:0] read_list_q, read_list_d, read_live;

  logic [NrVInsn-1:0] hazard_vs1, hazard_vs2, hazard_vd, hazard_vm;
  logic               no_src;
  logic               stall;
  logic               accept;

  // An entry stops counting as soon as its ID has left the running vector
  // The stored copy is cleaned at the following edge
  always_comb begin
    for (int unsigned v = 0; v < NrVRegs; v++) begin
      write_live[v]       = write_list_q[v];
      write_live[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
      read_live[v]        = read_list_q[v];
      read_live[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
    end
  end

  ////////////////////
  // Hazards
  ////////////////////

  always_comb begin
    hazard_vs1 = '0;
    hazard_vs2 = '0;
    hazard_vd  = '0;
    hazard_vm  = '0;

    // Read after write on each source and on the mask register
    if (req_use_vs1_i) hazard_vs1 |= id_vec(write_live[req_vs1_i]);
    if (req_use_vs2_i) hazard_vs2 |= id_vec(write_live[req_vs2_i]);
    if (!req_vm_i)     hazard_vm  |= id_vec(write_live[VMaskReg]);

    if (req_use_vd_i) begin
      // Write after read blocks every operand path of the new instruction
      hazard_vs1 |= id_vec(read_live[req_vd_i]);
      hazard_vs2 |= id_vec(read_live[req_vd_i]);
      hazard_vm  |= id_vec(read_live[req_vd_i]);
      // Write after write keeps the result order on vd
      hazard_vd  |= id_vec(write_live[req_vd_i]);
    end
  end

  // Instructions that read no vector operand cannot be chained
  // They wait here until every dependency has retired
  assign no_src = !req_use_vs1_i && !req_use_vs2_i && req_vm_i;
  assign stall  = no_src && |{hazard_vs1, hazard_vs2, hazard_vd, hazard_vm};

  // A request needs a free ID and an empty issue register
  assign req_ready_o = !issue.hold && !full_i && !stall;
  assign accept      = req_valid_i && req_ready_o;

  // The new ID becomes the writer of vd and the reader of its sources
  always_comb begin
    write_list_d = write_live;
    read_list_d  = read_live;
    if (accept) begin
      if (req_use_vd_i)  write_list_d[req_vd_i] = '{vid: next_id_i, valid: 1'b1};
      if (req_use_vs1_i) read_list_d[req_vs1_i] = '{vid: next_id_i, valid: 1'b1};
      if (req_use_vs2_i) read_list_d[req_vs2_i] = '{vid: next_id_i, valid: 1'b1};
      if (!req_vm_i)     read_list_d[VMaskReg]  = '{vid: next_id_i, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_list_q <= '0;
      read_list_q  <= '0;
    end else begin
      write_list_q <= write_list_d;
      read_list_q  <= read_list_d;
    end
  end

  ////////////////////
  // Issue bus
  ////////////////////

  assign issue.accept     = accept;
  assign issue.id         = next_id_i;
  assign issue.op         = req_op_i;
  assign issue.vm         = req_vm_i;
  assign issue.vs1        = req_vs1_i;
  assign issue.use_vs1    = req_use_vs1_i;
  assign issue.vs2        = req_vs2_i;
  assign issue.use_vs2    = req_use_vs2_i;
  assign issue.vd         = req_vd_i;
  assign issue.use_vd     = req_use_vd_i;
  assign issue.hazard_vs1 = hazard_vs1;
  assign issue.hazard_vs2 = hazard_vs2;
  assign issue.hazard_vd  = hazard_vd;
  assign issue.hazard_vm  = hazard_vm;

endmodule

// File: hdl/vseq_issue_reg.sv
// PE request register

module vseq_issue_reg #(
  parameter  int unsigned NrVInsn = 8,
  parameter  int unsigned NrLanes = 2,
  localparam int unsigned IdW     = (NrVInsn > 1) ? $clog2(NrVInsn) : 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Accepted instruction from the hazard checker
  vseq_issue_if.buffer          issue,
  // One ready bit per lane
  input  logic    [NrLanes-1:0] lane_ready_i,
  // Request towards the processing elements
  output logic                  pe_req_valid_o,
  output logic        [IdW-1:0] pe_id_o,
  output vseq_pkg::op_e         pe_op_o,
  output logic                  pe_vm_o,
  output vseq_pkg::vreg_t       pe_vs1_o,
  output vseq_pkg::vreg_t       pe_vs2_o,
  output vseq_pkg::vreg_t       pe_vd_o,
  output logic    [NrVInsn-1:0] pe_hazard_vs1_o,
  output logic    [NrVInsn-1:0] pe_hazard_vs2_o,
  output logic    [NrVInsn-1:0] pe_hazard_vd_o,
  output logic    [NrVInsn-1:0] pe_hazard_vm_o
);

  logic lanes_ready;

  // The request only leaves once every lane has taken it in the same cycle
  assign lanes_ready = &lane_ready_i;

  // Keep new requests out while the current one is stuck
  assign issue.hold = pe_req_valid_o && !lanes_ready;

  // A new instruction may replace the one leaving in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (issue.accept) begin
      pe_req_valid_o <= 1'b1;
    end else if (lanes_ready) begin
      pe_req_valid_o <= 1'b0;
    end
  end

  // Payload only changes on acceptance
  always_ff @(posedge clk_i) begin
    if (issue.accept) begin
      pe_id_o         <= issue.id;
      pe_op_o         <= issue.op;
      pe_vm_o         <= issue.vm;
      pe_vs1_o        <= issue.vs1;
      pe_vs2_o        <= issue.vs2;
      pe_vd_o         <= issue.vd;
      pe_hazard_vs1_o <= issue.hazard_vs1;
      pe_hazard_vs2_o <= issue.hazard_vs2;
      pe_hazard_vd_o  <= issue.hazard_vd;
      pe_hazard_vm_o  <= issue.hazard_vm;
    end
  end

endmodule

// File: hdl/vseq_tracker.sv
// Running instruction tracker

module vseq_tracker #(
  parameter  int unsigned NrVInsn = 8,
  parameter  int unsigned NrLanes = 2,
  localparam int unsigned NrPEs   = NrLanes + 2,
  localparam int unsigned IdW     = (NrVInsn > 1) ? $clog2(NrVInsn) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Accepted instruction from the hazard checker
  vseq_issue_if.tracker                      issue,
  // Completion pulses with one row per PE
  input  logic    [NrPEs-1:0][NrVInsn-1:0]   pe_done_i,
  // State back to the hazard checker
  output logic               [NrVInsn-1:0]   running_o,
  output logic                   [IdW-1:0]   next_id_o,
  output logic                               full_o,
  // Status towards the PEs and the operand requesters
  output logic               [NrVInsn-1:0]   vinsn_running_o,
  output logic  [NrVInsn-1:0][NrVInsn-1:0]   global_hazard_table_o,
  output logic                               idle_o
);
  import vseq_pkg::*;

  ////////////////////
  // Running matrix
  ////////////////////

  // Bit [pe][id] is set while instruction id still runs on that PE
  logic [NrPEs-1:0][NrVInsn-1:0] pe_running_d, pe_running_q;

  // Bit [id] is set while instruction id runs anywhere
  logic [NrVInsn-1:0] running_d, running_q;

  always_comb begin
    pe_running_d = pe_running_q & ~pe_done_i;

    // Mark the new ID on each PE its class targets
    if (issue.accept) begin
      unique case (issue.op)
        OP_ALU: begin
          for (int unsigned l = 0; l < NrLanes; l++) begin
            pe_running_d[l][issue.id] = 1'b1;
          end
        end
        OP_LOAD:  pe_running_d[NrLanes + OffsetLoad][issue.id]  = 1'b1;
        OP_STORE: pe_running_d[NrLanes + OffsetStore][issue.id] = 1'b1;
        default: ;
      endcase
    end

    // An ID stays alive until its last PE reports done
    running_d = '0;
    for (int unsigned pe = 0; pe < NrPEs; pe++) begin
      running_d |= pe_running_d[pe];
    end
  end

  ////////////////////
  // Hazard table
  ////////////////////

  // Row N lists the IDs that instruction N still waits for
  logic [NrVInsn-1:0][NrVInsn-1:0] table_d, table_q;

  always_comb begin
    table_d = table_q;
    if (issue.accept) begin
      table_d[issue.id] = issue.hazard_vs1 | issue.hazard_vs2 |
                          issue.hazard_vd  | issue.hazard_vm;
    end
    // Retired IDs drop out of every row at the same edge as their running bit
    for (int unsigned id = 0; id < NrVInsn; id++) begin
      table_d[id] &= running_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_running_q <= '0;
      running_q    <= '0;
      table_q      <= '0;
    end else begin
      pe_running_q <= pe_running_d;
      running_q    <= running_d;
      table_q      <= table_d;
    end
  end

  ////////////////////
  // Free ID search
  ////////////////////

  // Walk downwards so the lowest clear bit wins
  always_comb begin
    next_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) next_id_o = IdW'(i);
    end
  end

  // No clear bit means every ID is in flight
  assign full_o = &running_q;

  assign running_o             = running_q;
  assign vinsn_running_o       = running_q;
  assign global_hazard_table_o = table_q;
  assign idle_o                = ~|running_q;

endmodule

// File: hdl/vseq_top.sv
// Vector instruction sequencer

module vseq_top #(
  parameter  int unsigned NrLanes = 2,
  parameter  int unsigned NrVInsn = 8,
  localparam int unsigned NrPEs   = NrLanes + 2,
  localparam int unsigned IdW     = (NrVInsn > 1) ? $clog2(NrVInsn) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Instruction request
  input  logic                              req_valid_i,
  input  vseq_pkg::op_e                     req_op_i,
  input  logic                              req_vm_i,
  input  vseq_pkg::vreg_t                   req_vs1_i,
  input  logic                              req_use_vs1_i,
  input  vseq_pkg::vreg_t                   req_vs2_i,
  input  logic                              req_use_vs2_i,
  input  vseq_pkg::vreg_t                   req_vd_i,
  input  logic                              req_use_vd_i,
  output logic                              req_ready_o,
  // Request towards the processing elements
  output logic                              pe_req_valid_o,
  output logic                  [IdW-1:0]   pe_id_o,
  output vseq_pkg::op_e                     pe_op_o,
  output logic                              pe_vm_o,
  output vseq_pkg::vreg_t                   pe_vs1_o,
  output vseq_pkg::vreg_t                   pe_vs2_o,
  output vseq_pkg::vreg_t                   pe_vd_o,
  output logic              [NrVInsn-1:0]   pe_hazard_vs1_o,
  output logic              [NrVInsn-1:0]   pe_hazard_vs2_o,
  output logic              [NrVInsn-1:0]   pe_hazard_vd_o,
  output logic              [NrVInsn-1:0]   pe_hazard_vm_o,
  input  logic              [NrLanes-1:0]   pe_req_ready_i,
  // Completion pulses per PE and ID
  input  logic   [NrPEs-1:0][NrVInsn-1:0]   pe_done_i,
  // Sequencer status
  output logic              [NrVInsn-1:0]   vinsn_running_o,
  output logic [NrVInsn-1:0][NrVInsn-1:0]   global_hazard_table_o,
  output logic                              idle_o
);

  // Tracker state seen by the hazard checker
  logic [NrVInsn-1:0] running;
  logic     [IdW-1:0] next_id;
  logic               full;

  vseq_issue_if #(.NrVInsn(NrVInsn)) issue_if ();

  vseq_hazard_check #(.NrVInsn(NrVInsn)) i_hazard_check (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_op_i      (req_op_i),
    .req_vm_i      (req_vm_i),
    .req_vs1_i     (req_vs1_i),
    .req_use_vs1_i (req_use_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_use_vs2_i (req_use_vs2_i),
    .req_vd_i      (req_vd_i),
    .req_use_vd_i  (req_use_vd_i),
    .req_ready_o   (req_ready_o),
    .running_i     (running),
    .next_id_i     (next_id),
    .full_i        (full),
    .issue         (issue_if.producer)
  );

  vseq_issue_reg #(.NrVInsn(NrVInsn), .NrLanes(NrLanes)) i_issue_reg (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue           (issue_if.buffer),
    .lane_ready_i    (pe_req_ready_i),
    .pe_req_valid_o  (pe_req_valid_o),
    .pe_id_o         (pe_id_o),
    .pe_op_o         (pe_op_o),
    .pe_vm_o         (pe_vm_o),
    .pe_vs1_o        (pe_vs1_o),
    .pe_vs2_o        (pe_vs2_o),
    .pe_vd_o         (pe_vd_o),
    .pe_hazard_vs1_o (pe_hazard_vs1_o),
    .pe_hazard_vs2_o (pe_hazard_vs2_o),
    .pe_hazard_vd_o  (pe_hazard_vd_o),
    .pe_hazard_vm_o  (pe_hazard_vm_o)
  );

  vseq_tracker #(.NrVInsn(NrVInsn), .NrLanes(NrLanes)) i_tracker (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .issue                 (issue_if.tracker),
    .pe_done_i             (pe_done_i),
    .running_o             (running),
    .next_id_o             (next_id),
    .full_o                (full),
    .vinsn_running_o       (vinsn_running_o),
    .global_hazard_table_o (global_hazard_table_o),
    .idle_o                (idle_o)
  );

endmodule

// File: bench/vseq_tb_model.svh
// Sequencer reference model
`ifndef VSEQ_TB_MODEL_SVH
`define VSEQ_TB_MODEL_SVH

////////////////////
// Random source
////////////////////

// Fibonacci LFSR state, taps 32, 22, 2 and 1
logic [31:0] lfsr_q;

// Steps the LFSR once per bit and returns the feedback bits, newest in bit 0
function automatic logic [31:0] lfsr_bits(input int unsigned n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int unsigned i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    val    = {val[30:0], fb};
  end
  return val;
endfunction

// Registers come from v0 to v5 so that hazards show up often
function automatic vreg_t pick_reg();
  return vreg_t'(lfsr_bits(3) % 6);
endfunction

function automatic op_e pick_op();
  logic [31:0] val;
  val = lfsr_bits(2);
  if (val == 1) begin
    return OP_LOAD;
  end else if (val == 2) begin
    return OP_STORE;
  end
  return OP_ALU;
endfunction

////////////////////
// Model state
////////////////////

// Last writer and last reader of each vector register
id_t  wr_id_m [NrVRegs];
logic wr_ok_m [NrVRegs];
id_t  rd_id_m [NrVRegs];
logic rd_ok_m [NrVRegs];

// Running bits per PE, with the cycles each bit has been set
logic [NrVInsn-1:0] pe_run_m [NrPEs];
int unsigned        age_m [NrPEs][NrVInsn];

// Rows of the global hazard table
logic [NrVInsn-1:0] table_m [NrVInsn];

// Expected content of the PE request
logic               exp_valid_m;
id_t                exp_id_m;
op_e                exp_op_m;
logic               exp_vm_m;
vreg_t              exp_vs1_m;
vreg_t              exp_vs2_m;
vreg_t              exp_vd_m;
logic [NrVInsn-1:0] exp_hz_vs1_m;
logic [NrVInsn-1:0] exp_hz_vs2_m;
logic [NrVInsn-1:0] exp_hz_vd_m;
logic [NrVInsn-1:0] exp_hz_vm_m;

// An ID runs while any PE still holds its bit
function automatic logic [NrVInsn-1:0] running_vec();
  logic [NrVInsn-1:0] vec;
  vec = '0;
  for (int unsigned pe = 0; pe < NrPEs; pe++) begin
    vec |= pe_run_m[pe];
  end
  return vec;
endfunction

// Bit of the live writer of a register, if any
function automatic logic [NrVInsn-1:0] writer_vec(input vreg_t r,
                                                  input logic [NrVInsn-1:0] run);
  logic [NrVInsn-1:0] vec;
  vec = '0;
  if (wr_ok_m[r] && run[wr_id_m[r]]) begin
    vec[wr_id_m[r]] = 1'b1;
  end
  return vec;
endfunction

// Bit of the live reader of a register, if any
function automatic logic [NrVInsn-1:0] reader_vec(input vreg_t r,
                                                  input logic [NrVInsn-1:0] run);
  logic [NrVInsn-1:0] vec;
  vec = '0;
  if (rd_ok_m[r] && run[rd_id_m[r]]) begin
    vec[rd_id_m[r]] = 1'b1;
  end
  return vec;
endfunction

// State right after reset
task automatic clear_model();
  for (int unsigned v = 0; v < NrVRegs; v++) begin
    wr_id_m[v] = '0;
    wr_ok_m[v] = 1'b0;
    rd_id_m[v] = '0;
    rd_ok_m[v] = 1'b0;
  end
  for (int unsigned pe = 0; pe < NrPEs; pe++) begin
    pe_run_m[pe] = '0;
    for (int unsigned id = 0; id < NrVInsn; id++) begin
      age_m[pe][id] = 0;
    end
  end
  for (int unsigned id = 0; id < NrVInsn; id++) begin
    table_m[id] = '0;
  end
  exp_valid_m = 1'b0;
endtask

////////////////////
// Compare tasks
////////////////////

task automatic check_ready(input string name, input logic act, input logic exp);
  if (act !== exp) begin
    report_failure($sformatf("Fail %s: got 'h%h, expected 'h%h", name, act, exp));
  end
endtask

task automatic check_id(input string name, input id_t act, input id_t exp);
  if (act !== exp) begin
    report_failure($sformatf("Fail %s: got 'h%h, expected 'h%h", name, act, exp));
  end
endtask

task automatic check_vec(input string name, input logic [NrVInsn-1:0] act,
                         input logic [NrVInsn-1:0] exp);
  if (act !== exp) begin
    report_failure($sformatf("Fail %s: got 'h%h, expected 'h%h", name, act, exp));
  end
endtask

task automatic check_op(input string name, input op_e act, input op_e exp);
  if (act !== exp) begin
    report_failure($sformatf("Fail %s: got 'h%h, expected 'h%h", name, act, exp));
  end
endtask

task automatic check_reg(input string name, input vreg_t act, input vreg_t exp);
  if (act !== exp) begin
    report_failure($sformatf("Fail %s: got 'h%h, expected 'h%h", name, act, exp));
  end
endtask

`endif

// File: bench/vseq_tb.sv
// Vector sequencer testbench

module vseq_tb;
  timeunit 1ns;
  timeprecision 10ps;

  import vseq_pkg::*;

  localparam int unsigned NrLanes    = 2;
  localparam int unsigned NrVInsn    = 8;
  localparam int unsigned NrPEs      = NrLanes + 2;
  localparam int unsigned IdW        = $clog2(NrVInsn);
  localparam int unsigned NrAccepts  = 3000;
  localparam int unsigned Timeout    = 1000;
  // Oldest a running bit may get before its PE reports done
  localparam int unsigned MaxDoneAge = 10;

  typedef logic [IdW-1:0] id_t;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                            clk_i;
  logic                            rst_ni;
  logic                            req_valid_i;
  op_e                             req_op_i;
  logic                            req_vm_i;
  vreg_t                           req_vs1_i;
  logic                            req_use_vs1_i;
  vreg_t                           req_vs2_i;
  logic                            req_use_vs2_i;
  vreg_t                           req_vd_i;
  logic                            req_use_vd_i;
  logic                            req_ready_o;
  logic                            pe_req_valid_o;
  id_t                             pe_id_o;
  op_e                             pe_op_o;
  logic                            pe_vm_o;
  vreg_t                           pe_vs1_o;
  vreg_t                           pe_vs2_o;
  vreg_t                           pe_vd_o;
  logic [NrVInsn-1:0]              pe_hazard_vs1_o;
  logic [NrVInsn-1:0]              pe_hazard_vs2_o;
  logic [NrVInsn-1:0]              pe_hazard_vd_o;
  logic [NrVInsn-1:0]              pe_hazard_vm_o;
  logic [NrLanes-1:0]              pe_req_ready_i;
  logic [NrPEs-1:0][NrVInsn-1:0]   pe_done_i;
  logic [NrVInsn-1:0]              vinsn_running_o;
  logic [NrVInsn-1:0][NrVInsn-1:0] global_hazard_table_o;
  logic                            idle_o;

  // Progress and coverage counters
  int unsigned accepted;
  int unsigned stuck;
  int unsigned n_full;
  int unsigned n_stall;
  int unsigned n_chained;
  // The request on the bus waits for acceptance
  logic        pending;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  `include "vseq_tb_model.svh"

  vseq_top #(.NrLanes(NrLanes), .NrVInsn(NrVInsn)) dut0 (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_valid_i           (req_valid_i),
    .req_op_i              (req_op_i),
    .req_vm_i              (req_vm_i),
    .req_vs1_i             (req_vs1_i),
    .req_use_vs1_i         (req_use_vs1_i),
    .req_vs2_i             (req_vs2_i),
    .req_use_vs2_i         (req_use_vs2_i),
    .req_vd_i              (req_vd_i),
    .req_use_vd_i          (req_use_vd_i),
    .req_ready_o           (req_ready_o),
    .pe_req_valid_o        (pe_req_valid_o),
    .pe_id_o               (pe_id_o),
    .pe_op_o               (pe_op_o),
    .pe_vm_o               (pe_vm_o),
    .pe_vs1_o              (pe_vs1_o),
    .pe_vs2_o              (pe_vs2_o),
    .pe_vd_o               (pe_vd_o),
    .pe_hazard_vs1_o       (pe_hazard_vs1_o),
    .pe_hazard_vs2_o       (pe_hazard_vs2_o),
    .pe_hazard_vd_o        (pe_hazard_vd_o),
    .pe_hazard_vm_o        (pe_hazard_vm_o),
    .pe_req_ready_i        (pe_req_ready_i),
    .pe_done_i             (pe_done_i),
    .vinsn_running_o       (vinsn_running_o),
    .global_hazard_table_o (global_hazard_table_o),
    .idle_o                (idle_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  ////////////////////
  // Stimulus
  ////////////////////

  // Request fields, lane ready bits and done pulses for one cycle
  task automatic drive_inputs();
    logic [NrPEs-1:0][NrVInsn-1:0] done;
    // A waiting request keeps its fields until it is taken
    if (!pending) begin
      pending = lfsr_bits(3) != 0;
      if (pending) begin
        req_op_i      = pick_op();
        req_vm_i      = lfsr_bits(1) != 0;
        req_use_vs1_i = lfsr_bits(1) != 0;
        req_use_vs2_i = lfsr_bits(1) != 0;
        req_use_vd_i  = lfsr_bits(2) != 0;
        req_vs1_i     = pick_reg();
        req_vs2_i     = pick_reg();
        req_vd_i      = pick_reg();
      end
    end
    req_valid_i = pending;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      pe_req_ready_i[l] = lfsr_bits(3) != 0;
    end
    // PEs only retire what runs on them, and never later than MaxDoneAge
    done = '0;
    for (int unsigned pe = 0; pe < NrPEs; pe++) begin
      for (int unsigned id = 0; id < NrVInsn; id++) begin
        if (pe_run_m[pe][id]) begin
          if (age_m[pe][id] >= MaxDoneAge) begin
            done[pe][id] = 1'b1;
          end else begin
            done[pe][id] = lfsr_bits(4) == 0;
          end
        end
      end
    end
    pe_done_i = done;
  endtask

  ////////////////////
  // Checks
  ////////////////////

  // Registered outputs against the model state after the last edge
  task automatic check_outputs();
    logic [NrVInsn-1:0] run;
    run = running_vec();
    check_ready("pe_req_valid_o", pe_req_valid_o, exp_valid_m);
    if (exp_valid_m) begin
      check_id("pe_id_o", pe_id_o, exp_id_m);
      check_op("pe_op_o", pe_op_o, exp_op_m);
      check_ready("pe_vm_o", pe_vm_o, exp_vm_m);
      check_reg("pe_vs1_o", pe_vs1_o, exp_vs1_m);
      check_reg("pe_vs2_o", pe_vs2_o, exp_vs2_m);
      check_reg("pe_vd_o", pe_vd_o, exp_vd_m);
      check_vec("pe_hazard_vs1_o", pe_hazard_vs1_o, exp_hz_vs1_m);
      check_vec("pe_hazard_vs2_o", pe_hazard_vs2_o, exp_hz_vs2_m);
      check_vec("pe_hazard_vd_o", pe_hazard_vd_o, exp_hz_vd_m);
      check_vec("pe_hazard_vm_o", pe_hazard_vm_o, exp_hz_vm_m);
    end
    check_vec("vinsn_running_o", vinsn_running_o, run);
    for (int unsigned id = 0; id < NrVInsn; id++) begin
      check_vec($sformatf("global_hazard_table_o[%0d]", id),
                global_hazard_table_o[id], table_m[id]);
    end
    check_ready("idle_o", idle_o, run == '0);
  endtask

  // Checks req_ready_o, then moves the model to the state after the next edge
  task automatic step_model();
    logic [NrVInsn-1:0] run;
    logic [NrVInsn-1:0] hz_vs1;
    logic [NrVInsn-1:0] hz_vs2;
    logic [NrVInsn-1:0] hz_vd;
    logic [NrVInsn-1:0] hz_vm;
    logic [NrPEs-1:0]   target;
    logic               lanes_ok;
    logic               hold;
    logic               full;
    logic               no_src;
    logic               stall;
    logic               ready;
    logic               accept;
    id_t                free_id;

    run      = running_vec();
    lanes_ok = &pe_req_ready_i;
    hold     = exp_valid_m && !lanes_ok;
    full     = &run;
    free_id  = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!run[i]) begin
        free_id = id_t'(i);
      end
    end

    // RAW on the sources and on v0, WAR and WAW on vd
    hz_vs1 = req_use_vs1_i ? writer_vec(req_vs1_i, run) : '0;
    hz_vs2 = req_use_vs2_i ? writer_vec(req_vs2_i, run) : '0;
    hz_vm  = !req_vm_i ? writer_vec(vreg_t'(VMaskReg), run) : '0;
    hz_vd  = '0;
    if (req_use_vd_i) begin
      hz_vs1 |= reader_vec(req_vd_i, run);
      hz_vs2 |= reader_vec(req_vd_i, run);
      hz_vm  |= reader_vec(req_vd_i, run);
      hz_vd  |= writer_vec(req_vd_i, run);
    end

    no_src = !req_use_vs1_i && !req_use_vs2_i && req_vm_i;
    stall  = no_src && (|{hz_vs1, hz_vs2, hz_vd, hz_vm});
    ready  = !hold && !full && !stall;
    check_ready("req_ready_o", req_ready_o, ready);
    accept = req_valid_i && ready;

    if (req_valid_i && full && !hold) n_full++;
    if (req_valid_i && stall && !hold && !full) n_stall++;
    if (accept && !no_src && (|{hz_vs1, hz_vs2, hz_vd, hz_vm})) n_chained++;

    // Entries of retired IDs drop out
    for (int unsigned v = 0; v < NrVRegs; v++) begin
      wr_ok_m[v] = wr_ok_m[v] && run[wr_id_m[v]];
      rd_ok_m[v] = rd_ok_m[v] && run[rd_id_m[v]];
    end
    if (accept) begin
      if (req_use_vd_i) begin
        wr_id_m[req_vd_i] = free_id;
        wr_ok_m[req_vd_i] = 1'b1;
      end
      if (req_use_vs1_i) begin
        rd_id_m[req_vs1_i] = free_id;
        rd_ok_m[req_vs1_i] = 1'b1;
      end
      if (req_use_vs2_i) begin
        rd_id_m[req_vs2_i] = free_id;
        rd_ok_m[req_vs2_i] = 1'b1;
      end
      if (!req_vm_i) begin
        rd_id_m[VMaskReg] = free_id;
        rd_ok_m[VMaskReg] = 1'b1;
      end
    end

    // PEs that run the new instruction
    target = '0;
    case (req_op_i)
      OP_LOAD:  target[NrLanes + OffsetLoad] = 1'b1;
      OP_STORE: target[NrLanes + OffsetStore] = 1'b1;
      default:  target[NrLanes-1:0] = '1;
    endcase
    for (int unsigned pe = 0; pe < NrPEs; pe++) begin
      for (int unsigned id = 0; id < NrVInsn; id++) begin
        if (pe_done_i[pe][id]) pe_run_m[pe][id] = 1'b0;
        if (accept && target[pe] && id == free_id) begin
          pe_run_m[pe][id] = 1'b1;
          age_m[pe][id]    = 0;
        end else if (pe_run_m[pe][id]) begin
          age_m[pe][id]++;
        end
      end
    end

    // Table row of the new ID, then every row loses the retired IDs
    if (accept) table_m[free_id] = hz_vs1 | hz_vs2 | hz_vd | hz_vm;
    run = running_vec();
    for (int unsigned id = 0; id < NrVInsn; id++) begin
      table_m[id] &= run;
    end

    if (accept) begin
      exp_valid_m  = 1'b1;
      exp_id_m     = free_id;
      exp_op_m     = req_op_i;
      exp_vm_m     = req_vm_i;
      exp_vs1_m    = req_vs1_i;
      exp_vs2_m    = req_vs2_i;
      exp_vd_m     = req_vd_i;
      exp_hz_vs1_m = hz_vs1;
      exp_hz_vs2_m = hz_vs2;
      exp_hz_vd_m  = hz_vd;
      exp_hz_vm_m  = hz_vm;
      accepted++;
      stuck   = 0;
      pending = 1'b0;
    end else begin
      if (lanes_ok) exp_valid_m = 1'b0;
      stuck++;
    end
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_op_i       = OP_ALU;
    req_vm_i       = 1'b1;
    req_vs1_i      = '0;
    req_use_vs1_i  = 1'b0;
    req_vs2_i      = '0;
    req_use_vs2_i  = 1'b0;
    req_vd_i       = '0;
    req_use_vd_i   = 1'b0;
    pe_req_ready_i = '0;
    pe_done_i      = '0;
    lfsr_q         = 32'h6ca8_2bf4;
    pending        = 1'b0;
    accepted       = 0;
    stuck          = 0;
    n_full         = 0;
    n_stall        = 0;
    n_chained      = 0;
    clear_model();

    repeat (2) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    check_outputs();
    #20;
    check_ready("req_ready_o", req_ready_o, 1'b1);

    // Inputs change 5 ns after each edge, req_ready_o is read 20 ns later
    while (accepted < NrAccepts) begin
      @(posedge clk_i);
      #5;
      check_outputs();
      drive_inputs();
      #20;
      step_model();
      if (stuck >= Timeout) begin
        report_failure("Timeout: no request was accepted within 1000 cycles");
      end
    end

    if (n_full == 0 || n_stall == 0 || n_chained == 0) begin
      report_failure("Stimulus never reached a full ID pool, a stall or a chained hazard");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: vseq_top.f
+incdir+bench
hdl/vseq_pkg.sv
hdl/vseq_issue_if.sv
hdl/vseq_hazard_check.sv
hdl/vseq_issue_reg.sv
hdl/vseq_tracker.sv
hdl/vseq_top.sv
bench/vseq_tb.sv

// File: Bender.yml
package:
  name: vseq

sources:
  - files:
      - hdl/vseq_pkg.sv
      - hdl/vseq_issue_if.sv
      - hdl/vseq_hazard_check.sv
      - hdl/vseq_issue_reg.sv
      - hdl/vseq_tracker.sv
      - hdl/vseq_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/vseq_tb.sv
